//--- fdtd_mem_ctrl.f
fdtd_pkg.sv
mem_xfer_if.sv
axi_rd_engine.sv
axi_wr_engine.sv
field_addr_gen.sv
fdtd_sequencer.sv
irq_ctrl.sv
fdtd_mem_ctrl.sv
tb_axi_mem.sv
tb_fdtd_mem_ctrl.sv

//--- tb_fdtd_mem_ctrl.sv
`timescale 1ns/10ps

module tb_fdtd_mem_ctrl;
    import fdtd_pkg::*;

    localparam int    TIMEOUT = 5000;
    localparam addr_t HY_BASE = 32'h0000_0100;
    localparam addr_t EZ_BASE = 32'h0000_0300;

    // DUT inputs
    logic       ACLK, ARESETn, trigger_i, int_en_i, int_clr_i, calc_ack_i;
    logic       ar_ready_i, r_last_i, r_valid_i, aw_ready_i, w_ready_i, b_valid_i;
    field_e     update_field_i;
    addr_t      hy_base_i, ez_base_i;
    size_t      size_i;
    data_t      wr_data_i, r_data_i;
    logic [1:0] b_resp_i;

    // DUT outputs
    logic       busy_o, int_o, int_pending_o, calc_req_o, rd_valid_o, wr_pop_o;
    logic       ar_valid_o, r_ready_o, aw_valid_o, w_last_o, w_valid_o, b_ready_o;
    field_e     rd_field_o;
    data_t      rd_data_o, w_data_o;
    addr_t      ar_addr_o, aw_addr_o;
    logic [7:0] ar_len_o, aw_len_o;
    logic [2:0] ar_size_o, aw_size_o;
    logic [1:0] ar_burst_o, aw_burst_o;
    logic [3:0] w_strb_o;

    int     mismatches = 0;
    int     failures = 0;
    integer seed = 95031;
    data_t  old_mem [256];
    data_t  hy_buf [BURST_LEN];
    data_t  ez_buf [BURST_LEN];
    int     hy_cnt, ez_cnt, wr_idx, calc_dly;
    logic   calc_req_q;

    fdtd_mem_ctrl i_dut (.*);

    tb_axi_mem i_mem
    (
        .ACLK       ( ACLK       ),
        .ARESETn    ( ARESETn    ),
        .ar_addr_i  ( ar_addr_o  ),
        .ar_valid_i ( ar_valid_o ),
        .ar_ready_o ( ar_ready_i ),
        .r_data_o   ( r_data_i   ),
        .r_last_o   ( r_last_i   ),
        .r_valid_o  ( r_valid_i  ),
        .r_ready_i  ( r_ready_o  ),
        .aw_addr_i  ( aw_addr_o  ),
        .aw_valid_i ( aw_valid_o ),
        .aw_ready_o ( aw_ready_i ),
        .w_data_i   ( w_data_o   ),
        .w_last_i   ( w_last_o   ),
        .w_valid_i  ( w_valid_o  ),
        .w_ready_o  ( w_ready_i  ),
        .b_resp_o   ( b_resp_i   ),
        .b_valid_o  ( b_valid_i  ),
        .b_ready_i  ( b_ready_o  )
    );

    initial
    begin
        ACLK = 1'b0;
        forever #5 ACLK = ~ACLK;
    end

    task automatic note_failure(string what);
        $display("ERROR at %0t: %s", $time, what);
        failures++;
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            mismatches++;
        end
    endtask

    // next update word from the captured block
    function automatic data_t update_word(int idx);
        if (update_field_i == FIELD_HY)
            return hy_buf[idx] + ez_buf[idx];
        else
            return ez_buf[idx] - hy_buf[idx];
    endfunction

    ////////////////////////////////////////////////////////////
    // compute engine model and stream order checks
    ////////////////////////////////////////////////////////////
    always @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            calc_ack_i <= 1'b0;
            wr_data_i  <= '0;
            hy_cnt     <= 0;
            ez_cnt     <= 0;
            wr_idx     <= 0;
            calc_dly   <= 0;
            calc_req_q <= 1'b0;
        end
        else
        begin
            calc_req_q <= calc_req_o;
            if (rd_valid_o && rd_field_o == FIELD_HY)
            begin
                if (hy_cnt >= BURST_LEN || ez_cnt != 0)
                    note_failure("Hy word arrived out of order");
                else
                    hy_buf[hy_cnt] <= rd_data_o;
                hy_cnt <= hy_cnt + 1;
            end
            else if (rd_valid_o)
            begin
                // Ez only after the full Hy burst
                if (hy_cnt != BURST_LEN || ez_cnt >= BURST_LEN)
                    note_failure("Ez word arrived out of order");
                else
                    ez_buf[ez_cnt] <= rd_data_o;
                ez_cnt <= ez_cnt + 1;
            end

            if (calc_req_o && !calc_req_q)
            begin
                if (hy_cnt + ez_cnt != 2 * BURST_LEN)
                    note_failure("calc_req_o rose before all read beats of the block");
                hy_cnt    <= 0;
                ez_cnt    <= 0;
                wr_idx    <= 0;
                wr_data_i <= update_word(0);
            end

            if (calc_req_o && !calc_ack_i)
            begin
                if (calc_dly == 0)
                    calc_ack_i <= 1'b1;
                else
                    calc_dly <= calc_dly - 1;
            end
            else if (!calc_req_o && calc_ack_i)
            begin
                calc_ack_i <= 1'b0;
                calc_dly   <= $random(seed) & 7;
            end

            if (wr_pop_o)
            begin
                if (calc_req_o)
                    note_failure("write beat while calc_req_o is high");
                wr_idx <= wr_idx + 1;
                if (wr_idx + 1 < BURST_LEN)
                    wr_data_i <= update_word(wr_idx + 1);
            end

            if (!int_en_i && int_o)
                note_failure("int_o high while int_en_i is low");
        end
    end

    task automatic wait_busy(logic level, string what);
        int n;
        n = 0;
        while (busy_o !== level && n < TIMEOUT)
        begin
            @(negedge ACLK);
            n++;
        end
        if (busy_o !== level)
            note_failure({"timeout waiting for ", what});
    endtask

    task automatic start_run(field_e field, size_t words, logic irq_en);
        for (int i = 0; i < 256; i++)
            old_mem[i] = i_mem.mem[i];
        @(posedge ACLK);
        update_field_i <= field;
        size_i         <= words;
        int_en_i       <= irq_en;
        trigger_i      <= 1'b1;
        @(posedge ACLK);
        trigger_i <= 1'b0;
        @(negedge ACLK);
        wait_busy(1'b1, "busy_o to rise");
        wait_busy(1'b0, "busy_o to fall");
    endtask

    task automatic clear_irq();
        @(posedge ACLK);
        int_clr_i <= 1'b1;
        @(posedge ACLK);
        int_clr_i <= 1'b0;
        @(negedge ACLK);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic test_reset_state();
        check_value("busy_o", busy_o, 0);
        check_value("int_o", int_o, 0);
        check_value("calc_req_o", calc_req_o, 0);
        check_value("ar_valid_o", ar_valid_o, 0);
        check_value("r_ready_o", r_ready_o, 0);
        check_value("aw_valid_o", aw_valid_o, 0);
        check_value("w_valid_o", w_valid_o, 0);
        check_value("b_ready_o", b_ready_o, 0);
    endtask

    // INCR bursts of BURST_LEN 4-byte beats with all byte lanes written
    task automatic test_axi_attrs();
        check_value("ar_len_o", ar_len_o, BURST_LEN - 1);
        check_value("ar_size_o", ar_size_o, 3'd2);
        check_value("ar_burst_o", ar_burst_o, 2'b01);
        check_value("aw_len_o", aw_len_o, BURST_LEN - 1);
        check_value("aw_size_o", aw_size_o, 3'd2);
        check_value("aw_burst_o", aw_burst_o, 2'b01);
        check_value("w_strb_o", w_strb_o, 4'hf);
    endtask

    task automatic test_hy_one_block();
        int hy;
        int ez;
        hy = HY_BASE >> 2;
        ez = EZ_BASE >> 2;
        start_run(FIELD_HY, size_t'(BURST_LEN), 1'b1);
        for (int i = 0; i < BURST_LEN; i++)
        begin
            check_value($sformatf("mem[%0d]", hy + i), i_mem.mem[hy + i],
                        old_mem[hy + i] + old_mem[ez + i]);
            check_value($sformatf("mem[%0d]", ez + i), i_mem.mem[ez + i], old_mem[ez + i]);
        end
        repeat (2) @(negedge ACLK);
        check_value("int_pending_o", int_pending_o, 1);
        check_value("int_o", int_o, 1);
        clear_irq();
        check_value("int_pending_o", int_pending_o, 0);
        check_value("int_o", int_o, 0);
    endtask

    // three blocks with the interrupt masked
    task automatic test_ez_multi_block();
        int hy;
        int ez;
        int n;
        hy = HY_BASE >> 2;
        ez = EZ_BASE >> 2;
        n  = 3 * BURST_LEN;
        start_run(FIELD_EZ, size_t'(n), 1'b0);
        for (int i = 0; i < n; i++)
        begin
            check_value($sformatf("mem[%0d]", ez + i), i_mem.mem[ez + i],
                        old_mem[ez + i] - old_mem[hy + i]);
            check_value($sformatf("mem[%0d]", hy + i), i_mem.mem[hy + i], old_mem[hy + i]);
        end
        check_value($sformatf("mem[%0d]", ez - 1), i_mem.mem[ez - 1], old_mem[ez - 1]);
        check_value($sformatf("mem[%0d]", ez + n), i_mem.mem[ez + n], old_mem[ez + n]);
        repeat (2) @(negedge ACLK);
        check_value("int_pending_o", int_pending_o, 1);
        check_value("int_o", int_o, 0);
        clear_irq();
    endtask

    initial
    begin
        ARESETn        <= 1'b0;
        trigger_i      <= 1'b0;
        update_field_i <= FIELD_HY;
        hy_base_i      <= HY_BASE;
        ez_base_i      <= EZ_BASE;
        size_i         <= '0;
        int_en_i       <= 1'b0;
        int_clr_i      <= 1'b0;
        repeat (8) @(posedge ACLK);
        ARESETn <= 1'b1;
        @(negedge ACLK);

        test_reset_state();
        test_axi_attrs();
        test_hy_one_block();
        test_ez_multi_block();

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- tb_axi_mem.sv
`timescale 1ns/10ps

module tb_axi_mem
(
    input  logic            ACLK,
    input  logic            ARESETn,

    input  fdtd_pkg::addr_t ar_addr_i,
    input  logic            ar_valid_i,
    output logic            ar_ready_o,
    output fdtd_pkg::data_t r_data_o,
    output logic            r_last_o,
    output logic            r_valid_o,
    input  logic            r_ready_i,

    input  fdtd_pkg::addr_t aw_addr_i,
    input  logic            aw_valid_i,
    output logic            aw_ready_o,
    input  fdtd_pkg::data_t w_data_i,
    input  logic            w_last_i,
    input  logic            w_valid_i,
    output logic            w_ready_o,
    output logic [1:0]      b_resp_o,
    output logic            b_valid_o,
    input  logic            b_ready_i
);
    import fdtd_pkg::*;

    localparam int MEM_WORDS = 256;

    data_t      mem [MEM_WORDS];
    integer     seed = 95031;
    logic       rd_busy;
    logic [7:0] rd_idx;
    int         rd_cnt;
    logic       wr_busy;
    logic [7:0] wr_idx;
    logic       r_hs;
    logic [7:0] r_next;

    // always OKAY
    assign b_resp_o = 2'b00;

    always @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            ar_ready_o <= 1'b0;
            r_data_o   <= '0;
            r_last_o   <= 1'b0;
            r_valid_o  <= 1'b0;
            aw_ready_o <= 1'b0;
            w_ready_o  <= 1'b0;
            b_valid_o  <= 1'b0;
            rd_busy    <= 1'b0;
            rd_idx     <= '0;
            rd_cnt     <= 0;
            wr_busy    <= 1'b0;
            wr_idx     <= '0;
            // fill pattern over the whole word address
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= (32'(i) * 32'h0101_0101) ^ 32'h3c5a_0000;
        end
        else
        begin
            ////////////////////////////////////////////////////////////
            // read side
            ////////////////////////////////////////////////////////////
            r_hs = r_valid_o && r_ready_i;
            if (ar_valid_i && ar_ready_o)
            begin
                rd_busy    <= 1'b1;
                rd_idx     <= ar_addr_i[9:2];
                rd_cnt     <= 0;
                ar_ready_o <= 1'b0;
            end
            else
                ar_ready_o <= !rd_busy && (($random(seed) & 3) != 0);

            if (r_hs)
            begin
                rd_idx <= rd_idx + 1'b1;
                rd_cnt <= rd_cnt + 1;
                if (r_last_o)
                    rd_busy <= 1'b0;
            end
            // a presented beat is held until it is taken
            if (!r_valid_o || r_hs)
            begin
                r_next = r_hs ? rd_idx + 1'b1 : rd_idx;
                if (rd_busy && !(r_hs && r_last_o) && (($random(seed) & 3) != 0))
                begin
                    r_valid_o <= 1'b1;
                    r_data_o  <= mem[r_next];
                    r_last_o  <= ((r_hs ? rd_cnt + 1 : rd_cnt) == BURST_LEN - 1);
                end
                else
                    r_valid_o <= 1'b0;
            end

            ////////////////////////////////////////////////////////////
            // write side
            ////////////////////////////////////////////////////////////
            if (aw_valid_i && aw_ready_o)
            begin
                wr_busy    <= 1'b1;
                wr_idx     <= aw_addr_i[9:2];
                aw_ready_o <= 1'b0;
            end
            else
                aw_ready_o <= !wr_busy && !b_valid_o && (($random(seed) & 3) != 0);

            if (w_valid_i && w_ready_o)
            begin
                mem[wr_idx] <= w_data_i;
                wr_idx      <= wr_idx + 1'b1;
                if (w_last_i)
                begin
                    wr_busy   <= 1'b0;
                    b_valid_o <= 1'b1;
                end
            end
            w_ready_o <= wr_busy && !(w_valid_i && w_ready_o && w_last_i)
                         && (($random(seed) & 3) != 0);

            if (b_valid_o && b_ready_i)
                b_valid_o <= 1'b0;
        end
    end

endmodule

//--- fdtd_mem_ctrl.sv
`timescale 1ns/10ps

module fdtd_mem_ctrl
(
    input  logic                          ACLK,
    input  logic                          ARESETn,

    // host
    input  logic                          trigger_i,
    input  fdtd_pkg::field_e              update_field_i,
    input  fdtd_pkg::addr_t               hy_base_i,
    input  fdtd_pkg::addr_t               ez_base_i,
    input  fdtd_pkg::size_t               size_i,
    input  logic                          int_en_i,
    input  logic                          int_clr_i,
    output logic                          busy_o,
    output logic                          int_o,
    output logic                          int_pending_o,

    // compute engine
    output logic                          calc_req_o,
    input  logic                          calc_ack_i,
    output logic                          rd_valid_o,
    output fdtd_pkg::field_e              rd_field_o,
    output fdtd_pkg::data_t               rd_data_o,
    output logic                          wr_pop_o,
    input  fdtd_pkg::data_t               wr_data_i,

    // AXI read channels
    output fdtd_pkg::addr_t               ar_addr_o,
    output logic [7:0]                    ar_len_o,
    output logic [2:0]                    ar_size_o,
    output logic [1:0]                    ar_burst_o,
    output logic                          ar_valid_o,
    input  logic                          ar_ready_i,
    input  fdtd_pkg::data_t               r_data_i,
    input  logic                          r_last_i,
    input  logic                          r_valid_i,
    output logic                          r_ready_o,

    // AXI write channels
    output fdtd_pkg::addr_t               aw_addr_o,
    output logic [7:0]                    aw_len_o,
    output logic [2:0]                    aw_size_o,
    output logic [1:0]                    aw_burst_o,
    output logic                          aw_valid_o,
    input  logic                          aw_ready_i,
    output fdtd_pkg::data_t               w_data_o,
    output logic [fdtd_pkg::DATA_W/8-1:0] w_strb_o,
    output logic                          w_last_o,
    output logic                          w_valid_o,
    input  logic                          w_ready_i,
    // response code is not checked
    input  logic [1:0]                    b_resp_i,
    input  logic                          b_valid_i,
    output logic                          b_ready_o
);
    import fdtd_pkg::*;

    mem_xfer_if rd_xfer ();
    mem_xfer_if wr_xfer ();

    addr_t hy_addr;
    addr_t ez_addr;
    logic  last_block;
    logic  load;
    logic  advance;

    ////////////////////////////////////////////////////////////
    // compute side streams and fixed AXI attributes
    ////////////////////////////////////////////////////////////
    assign rd_valid_o   = rd_xfer.beat;
    assign rd_data_o    = rd_xfer.data;
    assign wr_pop_o     = wr_xfer.beat;
    assign wr_xfer.data = wr_data_i;

    assign ar_len_o     = AXI_LEN;
    assign ar_size_o    = AXI_SIZE;
    assign ar_burst_o   = AXI_BURST_INCR;
    assign aw_len_o     = AXI_LEN;
    assign aw_size_o    = AXI_SIZE;
    assign aw_burst_o   = AXI_BURST_INCR;
    assign w_strb_o     = AXI_STRB_ALL;

    fdtd_sequencer i_sequencer
    (
        .ACLK           ( ACLK           ),
        .ARESETn        ( ARESETn        ),
        .trigger_i      ( trigger_i      ),
        .update_field_i ( update_field_i ),
        .calc_ack_i     ( calc_ack_i     ),
        .hy_addr_i      ( hy_addr        ),
        .ez_addr_i      ( ez_addr        ),
        .last_block_i   ( last_block     ),
        .calc_req_o     ( calc_req_o     ),
        .busy_o         ( busy_o         ),
        .rd_field_o     ( rd_field_o     ),
        .load_o         ( load           ),
        .advance_o      ( advance        ),
        .rd_xfer        ( rd_xfer.ctrl   ),
        .wr_xfer        ( wr_xfer.ctrl   )
    );

    field_addr_gen i_addr_gen
    (
        .ACLK         ( ACLK       ),
        .ARESETn      ( ARESETn    ),
        .load_i       ( load       ),
        .advance_i    ( advance    ),
        .hy_base_i    ( hy_base_i  ),
        .ez_base_i    ( ez_base_i  ),
        .size_i       ( size_i     ),
        .hy_addr_o    ( hy_addr    ),
        .ez_addr_o    ( ez_addr    ),
        .last_block_o ( last_block )
    );

    axi_rd_engine i_rd_engine
    (
        .ACLK       ( ACLK       ),
        .ARESETn    ( ARESETn    ),
        .xfer       ( rd_xfer.rd ),
        .ar_addr_o  ( ar_addr_o  ),
        .ar_valid_o ( ar_valid_o ),
        .ar_ready_i ( ar_ready_i ),
        .r_data_i   ( r_data_i   ),
        .r_last_i   ( r_last_i   ),
        .r_valid_i  ( r_valid_i  ),
        .r_ready_o  ( r_ready_o  )
    );

    axi_wr_engine i_wr_engine
    (
        .ACLK       ( ACLK       ),
        .ARESETn    ( ARESETn    ),
        .xfer       ( wr_xfer.wr ),
        .aw_addr_o  ( aw_addr_o  ),
        .aw_valid_o ( aw_valid_o ),
        .aw_ready_i ( aw_ready_i ),
        .w_data_o   ( w_data_o   ),
        .w_last_o   ( w_last_o   ),
        .w_valid_o  ( w_valid_o  ),
        .w_ready_i  ( w_ready_i  ),
        .b_valid_i  ( b_valid_i  ),
        .b_ready_o  ( b_ready_o  )
    );

    irq_ctrl i_irq_ctrl
    (
        .ACLK          ( ACLK          ),
        .ARESETn       ( ARESETn       ),
        .busy_i        ( busy_o        ),
        .int_en_i      ( int_en_i      ),
        .int_clr_i     ( int_clr_i     ),
        .int_pending_o ( int_pending_o ),
        .int_o         ( int_o         )
    );

endmodule

//--- irq_ctrl.sv
`timescale 1ns/10ps

module irq_ctrl
(
    input  logic ACLK,
    input  logic ARESETn,

    input  logic busy_i,
    input  logic int_en_i,
    input  logic int_clr_i,

    output logic int_pending_o,
    output logic int_o
);

    logic busy_q;

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (~ARESETn)
            busy_q <= 1'b0;
        else
            busy_q <= busy_i;
    end

    // clear has priority over the busy falling edge
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (~ARESETn)
            int_pending_o <= 1'b0;
        else if (int_clr_i)
            int_pending_o <= 1'b0;
        else if (busy_q && !busy_i)
            int_pending_o <= 1'b1;
    end

    assign int_o = int_en_i & int_pending_o;

endmodule

//--- fdtd_sequencer.sv
`timescale 1ns/10ps

module fdtd_sequencer
(
    input  logic             ACLK,
    input  logic             ARESETn,

    input  logic             trigger_i,
    input  fdtd_pkg::field_e update_field_i,
    input  logic             calc_ack_i,

    input  fdtd_pkg::addr_t  hy_addr_i,
    input  fdtd_pkg::addr_t  ez_addr_i,
    input  logic             last_block_i,

    output logic             calc_req_o,
    output logic             busy_o,
    output fdtd_pkg::field_e rd_field_o,
    output logic             load_o,
    output logic             advance_o,

    mem_xfer_if.ctrl         rd_xfer,
    mem_xfer_if.ctrl         wr_xfer
);
    import fdtd_pkg::*;

    seq_state_e state;
    field_e     field_q;

    // req released after the engine ack until the ack drops
    logic       phase_rel;
    logic       xfer_ack;

    assign xfer_ack = (state == S_WR) ? wr_xfer.ack : rd_xfer.ack;

    ////////////////////////////////////////////////////////////
    // phase state machine
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (~ARESETn)
        begin
            state     <= S_IDLE;
            field_q   <= FIELD_HY;
            phase_rel <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (trigger_i)
                    begin
                        field_q <= update_field_i;
                        state   <= S_RD_HY;
                    end

                S_RD_HY, S_RD_EZ, S_WR:
                begin
                    if (!phase_rel && xfer_ack)
                        phase_rel <= 1'b1;
                    else if (phase_rel && !xfer_ack)
                    begin
                        phase_rel <= 1'b0;
                        if (state == S_RD_HY)
                            state <= S_RD_EZ;
                        else if (state == S_RD_EZ)
                            state <= S_CALC_REQ;
                        else if (last_block_i)
                            state <= S_IDLE;
                        else
                            state <= S_NEXT;
                    end
                end

                // compute engine handshake
                S_CALC_REQ:
                    if (calc_ack_i)
                        state <= S_CALC_REL;
                S_CALC_REL:
                    if (!calc_ack_i)
                        state <= S_WR;

                S_NEXT:
                    state <= S_RD_HY;

                default:
                    state <= S_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // requests and addresses
    ////////////////////////////////////////////////////////////
    assign rd_xfer.req  = (state == S_RD_HY || state == S_RD_EZ) && !phase_rel;
    assign rd_xfer.addr = (state == S_RD_EZ) ? ez_addr_i : hy_addr_i;

    // write back to whichever field is being updated
    assign wr_xfer.req  = (state == S_WR) && !phase_rel;
    assign wr_xfer.addr = (field_q == FIELD_HY) ? hy_addr_i : ez_addr_i;

    assign calc_req_o   = (state == S_CALC_REQ);
    assign busy_o       = (state != S_IDLE);
    assign rd_field_o   = (state == S_RD_EZ) ? FIELD_EZ : FIELD_HY;

    assign load_o       = (state == S_IDLE) && trigger_i;
    assign advance_o    = (state == S_NEXT);

endmodule

//--- field_addr_gen.sv
`timescale 1ns/10ps

module field_addr_gen
(
    input  logic            ACLK,
    input  logic            ARESETn,

    input  logic            load_i,
    input  logic            advance_i,

    input  fdtd_pkg::addr_t hy_base_i,
    input  fdtd_pkg::addr_t ez_base_i,
    input  fdtd_pkg::size_t size_i,

    output fdtd_pkg::addr_t hy_addr_o,
    output fdtd_pkg::addr_t ez_addr_o,
    output logic            last_block_o
);
    import fdtd_pkg::*;

    // words still to be processed, current block included
    size_t remain_q;

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (~ARESETn)
        begin
            hy_addr_o <= '0;
            ez_addr_o <= '0;
            remain_q  <= '0;
        end
        else if (load_i)
        begin
            hy_addr_o <= hy_base_i;
            ez_addr_o <= ez_base_i;
            remain_q  <= size_i;
        end
        else if (advance_i)
        begin
            // both fields step together, one block at a time
            hy_addr_o <= hy_addr_o + addr_t'(BURST_BYTES);
            ez_addr_o <= ez_addr_o + addr_t'(BURST_BYTES);
            remain_q  <= remain_q - size_t'(BURST_LEN);
        end
    end

    assign last_block_o = (remain_q == size_t'(BURST_LEN));

endmodule

//--- axi_wr_engine.sv
`timescale 1ns/10ps

module axi_wr_engine
(
    input  logic            ACLK,
    input  logic            ARESETn,

    mem_xfer_if.wr          xfer,

    output fdtd_pkg::addr_t aw_addr_o,
    output logic            aw_valid_o,
    input  logic            aw_ready_i,

    output fdtd_pkg::data_t w_data_o,
    output logic            w_last_o,
    output logic            w_valid_o,
    input  logic            w_ready_i,

    input  logic            b_valid_i,
    output logic            b_ready_o
);
    import fdtd_pkg::*;

    typedef enum logic [2:0]
    {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        WR_ACK
    } wr_state_e;

    wr_state_e         state;
    addr_t             addr_q;
    logic [BEAT_W-1:0] beat_cnt;
    logic              w_hs;

    always_ff @(posedge ACLK)
    begin
        if (state == WR_IDLE && xfer.req)
            addr_q <= xfer.addr;
    end

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (~ARESETn)
            state <= WR_IDLE;
        else
        begin
            case (state)
                WR_IDLE:
                    if (xfer.req)
                        state <= WR_ADDR;
                WR_ADDR:
                    if (aw_ready_i)
                        state <= WR_DATA;
                WR_DATA:
                    if (w_hs && w_last_o)
                        state <= WR_RESP;
                WR_RESP:
                    if (b_valid_i)
                        state <= WR_ACK;
                WR_ACK:
                    if (!xfer.req)
                        state <= WR_IDLE;
                default:
                    state <= WR_IDLE;
            endcase
        end
    end

    // beat index within the burst
    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (~ARESETn)
            beat_cnt <= '0;
        else if (state == WR_IDLE)
            beat_cnt <= '0;
        else if (w_hs)
            beat_cnt <= beat_cnt + 1'b1;
    end

    assign aw_addr_o  = addr_q;
    assign aw_valid_o = (state == WR_ADDR);

    // compute side presents the next word until it is popped
    assign w_data_o   = xfer.data;
    assign w_valid_o  = (state == WR_DATA);
    assign w_last_o   = (beat_cnt == BEAT_W'(BURST_LEN - 1));
    assign w_hs       = w_valid_o & w_ready_i;

    assign b_ready_o  = (state == WR_RESP);

    assign xfer.beat  = w_hs;
    assign xfer.ack   = (state == WR_ACK);

endmodule

//--- axi_rd_engine.sv
`timescale 1ns/10ps

module axi_rd_engine
(
    input  logic            ACLK,
    input  logic            ARESETn,

    mem_xfer_if.rd          xfer,

    output fdtd_pkg::addr_t ar_addr_o,
    output logic            ar_valid_o,
    input  logic            ar_ready_i,

    input  fdtd_pkg::data_t r_data_i,
    input  logic            r_last_i,
    input  logic            r_valid_i,
    output logic            r_ready_o
);
    import fdtd_pkg::*;

    typedef enum logic [1:0]
    {
        RD_IDLE,
        RD_ADDR,
        RD_DATA,
        RD_ACK
    } rd_state_e;

    rd_state_e state;
    addr_t     addr_q;
    logic      r_hs;

    // burst address taken when the request is seen
    always_ff @(posedge ACLK)
    begin
        if (state == RD_IDLE && xfer.req)
            addr_q <= xfer.addr;
    end

    always_ff @(posedge ACLK, negedge ARESETn)
    begin
        if (~ARESETn)
            state <= RD_IDLE;
        else
        begin
            case (state)
                RD_IDLE:
                    if (xfer.req)
                        state <= RD_ADDR;
                RD_ADDR:
                    if (ar_ready_i)
                        state <= RD_DATA;
                RD_DATA:
                    if (r_hs && r_last_i)
                        state <= RD_ACK;
                // hold ack until the sequencer lets go
                RD_ACK:
                    if (!xfer.req)
                        state <= RD_IDLE;
                default:
                    state <= RD_IDLE;
            endcase
        end
    end

    assign ar_addr_o  = addr_q;
    assign ar_valid_o = (state == RD_ADDR);
    assign r_ready_o  = (state == RD_DATA);
    assign r_hs       = r_valid_i & r_ready_o;

    // every accepted R beat goes straight to the compute side
    assign xfer.beat  = r_hs;
    assign xfer.data  = r_data_i;
    assign xfer.ack   = (state == RD_ACK);

endmodule

//--- mem_xfer_if.sv
`timescale 1ns/10ps

interface mem_xfer_if;
    import fdtd_pkg::*;

    // four-phase request from the sequencer
    logic  req;
    logic  ack;
    addr_t addr;

    // one pulse per word moved, with its data
    logic  beat;
    data_t data;

    modport ctrl
    (
        output req,
        output addr,
        input  ack
    );

    modport rd
    (
        input  req,
        input  addr,
        output ack,
        output beat,
        output data
    );

    modport wr
    (
        input  req,
        input  addr,
        input  data,
        output ack,
        output beat
    );

endinterface

//--- fdtd_pkg.sv
package fdtd_pkg;

    ////////////////////////////////////////////////////////////
    // field word and bus widths
    ////////////////////////////////////////////////////////////
    localparam int DATA_W      = 32;
    localparam int ADDR_W      = 32;
    localparam int SIZE_W      = 16;

    // one block of field words per AXI burst
    localparam int BURST_LEN   = 8;
    localparam int WORD_BYTES  = DATA_W / 8;
    localparam int BURST_BYTES = BURST_LEN * WORD_BYTES;
    localparam int BEAT_W      = $clog2(BURST_LEN);

    // fixed AXI attributes
    localparam logic [7:0]          AXI_LEN        = 8'(BURST_LEN - 1);
    localparam logic [2:0]          AXI_SIZE       = 3'($clog2(WORD_BYTES));
    localparam logic [1:0]          AXI_BURST_INCR = 2'b01;
    localparam logic [WORD_BYTES-1:0] AXI_STRB_ALL = '1;

    ////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [SIZE_W-1:0] size_t;

    // which field is streamed or updated
    typedef enum logic
    {
        FIELD_HY,
        FIELD_EZ
    } field_e;

    // block sequencer phases
    typedef enum logic [2:0]
    {
        S_IDLE,
        S_RD_HY,
        S_RD_EZ,
        S_CALC_REQ,
        S_CALC_REL,
        S_WR,
        S_NEXT
    } seq_state_e;

endpackage
